//--- logic/cft_params.svh
// CFT register section parameters
// Word width, bus source and target codes, front-panel dwell time

`ifndef CFT_PARAMS_SVH
`define CFT_PARAMS_SVH

////////////////////////////////////////////////////////////
// Datapath width
////////////////////////////////////////////////////////////

// Register and internal bus width
`define CFT_WORD_W 16

////////////////////////////////////////////////////////////
// Bus source and target codes
////////////////////////////////////////////////////////////

// Shared by read_sel and write_sel
`define CFT_SRC_NONE 3'd0
`define CFT_SRC_PC   3'd1
`define CFT_SRC_DR   3'd2
`define CFT_SRC_AC   3'd3
`define CFT_SRC_SP   3'd4
// On write_sel this sends the bus out, no register loads
`define CFT_SRC_EXT  3'd5

// Front panel
// Cycles each panel byte is shown, strobe cycle included
`define CFT_PANEL_DWELL 8

`endif

//--- logic/cft_pkg.sv
// CFT register section types
// Word, byte and bus code types plus the panel scanner states

`include "cft_params.svh"

package cft_pkg;

   // One register value or one internal bus word
   typedef logic [`CFT_WORD_W-1:0] word_t;

   // One front-panel byte, half a word
   typedef logic [`CFT_WORD_W/2-1:0] half_t;

   // Bus source or target code
   typedef logic [2:0] src_t;

   // Front-panel scanner states
   // SCAN_IDLE  one cycle after reset
   // SCAN_HOLD  position shown, dwell counter running
   // SCAN_LATCH strobe high, byte captured
   typedef enum logic [1:0] {
      SCAN_IDLE,
      SCAN_HOLD,
      SCAN_LATCH
   } panel_state_t;

endpackage

//--- logic/reg_major.sv
// CFT major register
// Loadable up/down register with zero and negative flags and an
// optional link flag that toggles when the value wraps

`include "cft_params.svh"

module reg_major
   import cft_pkg::*;
#(
   // Decrement path present
   parameter bit HAS_DEC  = 1'b1,
   // Link flag present
   parameter bit HAS_LINK = 1'b0
) (
   input  logic  clk,
   input  logic  reset,
   // Load from internal bus
   input  logic  ld,
   input  logic  inc,
   input  logic  dec,
   input  word_t d,
   output word_t q,
   // Zero, negative and link flags
   output logic  fz,
   output logic  fn,
   output logic  fl
);

   word_t q_r;
   logic  link_r;
   // Decrement as seen by this register
   logic  dec_en;
   // Wrap events that really take effect this cycle
   logic  wrap_up;
   logic  wrap_dn;

   ////////////////////////////////////////////////////////////
   // Operation decode
   ////////////////////////////////////////////////////////////

   // Registers without a down count ignore dec
   assign dec_en = HAS_DEC ? dec : 1'b0;

   // Carry out, FFFF rolling over to 0000
   // Only counts when no load wins
   assign wrap_up = ~ld & inc & (q_r == '1);

   // Borrow out, 0000 rolling under to FFFF
   // Increment beats decrement
   assign wrap_dn = ~ld & ~inc & dec_en & (q_r == '0);

   ////////////////////////////////////////////////////////////
   // Register value
   ////////////////////////////////////////////////////////////

   // Priority is load, then increment, then decrement
   always_ff @(posedge clk) begin
      if (reset) begin
         q_r <= '0;
      end else if (ld) begin
         q_r <= d;
      end else if (inc) begin
         q_r <= q_r + word_t'(1);
      end else if (dec_en) begin
         q_r <= q_r - word_t'(1);
      end
   end

   // Link flag, toggles on carry or borrow out
   // Stays clear when the register has no link
   always_ff @(posedge clk) begin
      if (reset) begin
         link_r <= 1'b0;
      end else if (HAS_LINK && (wrap_up || wrap_dn)) begin
         link_r <= ~link_r;
      end
   end

   // Outputs
   assign q  = q_r;
   // Flags straight from the stored value
   assign fz = (q_r == '0);
   assign fn = q_r[`CFT_WORD_W-1];
   assign fl = link_r;

   // Count strobes are mutually exclusive, as the control never
   // asks for both directions at once
   a_inc_dec_excl: assert property (
      @(posedge clk) disable iff (reset) !(inc && dec)
   ) else $error("reg_major: inc and dec high together");

endmodule

//--- logic/bus_arbiter.sv
// CFT bus arbiter
// Grants the internal word bus to one source, decodes the write
// target into register load strobes and routes the front-panel byte

`include "cft_params.svh"

module bus_arbiter
   import cft_pkg::*;
(
   // Bus source, bus target, panel register
   input  src_t  read_sel,
   input  src_t  write_sel,
   input  src_t  panel_reg,
   input  logic  panel_hi,
   // Register values and the external data port
   input  word_t pc_q,
   input  word_t dr_q,
   input  word_t ac_q,
   input  word_t sp_q,
   input  word_t ext_data,
   output word_t ibus,
   // One load strobe per register
   output logic  pc_ld,
   output logic  dr_ld,
   output logic  ac_ld,
   output logic  sp_ld,
   output half_t panel_byte
);

   // Word picked for the panel before the half select
   word_t panel_word;

   ////////////////////////////////////////////////////////////
   // Internal word bus
   ////////////////////////////////////////////////////////////

   // Exactly one driver, idle bus reads as zero
   always_comb begin
      case (read_sel)
         `CFT_SRC_PC:  ibus = pc_q;
         `CFT_SRC_DR:  ibus = dr_q;
         `CFT_SRC_AC:  ibus = ac_q;
         `CFT_SRC_SP:  ibus = sp_q;
         `CFT_SRC_EXT: ibus = ext_data;
         // NONE and the unused codes 6, 7
         default:      ibus = '0;
      endcase
   end

   // Write target decode
   // EXT and NONE load nothing
   always_comb begin
      pc_ld = (write_sel == `CFT_SRC_PC);
      dr_ld = (write_sel == `CFT_SRC_DR);
      ac_ld = (write_sel == `CFT_SRC_AC);
      sp_ld = (write_sel == `CFT_SRC_SP);
      // Never two registers loaded from one bus cycle
      a_ld_onehot0: assert ($onehot0({pc_ld, dr_ld, ac_ld, sp_ld}))
         else $error("bus_arbiter: more than one load strobe");
   end

   ////////////////////////////////////////////////////////////
   // Front-panel byte path
   ////////////////////////////////////////////////////////////

   // Separate from ibus, the panel never holds up a transfer
   always_comb begin
      case (panel_reg)
         `CFT_SRC_PC: panel_word = pc_q;
         `CFT_SRC_DR: panel_word = dr_q;
         `CFT_SRC_AC: panel_word = ac_q;
         `CFT_SRC_SP: panel_word = sp_q;
         default:     panel_word = '0;
      endcase
   end

   // High or low half of the selected register
   assign panel_byte = panel_hi ? panel_word[`CFT_WORD_W-1:`CFT_WORD_W/2]
                                : panel_word[`CFT_WORD_W/2-1:0];

endmodule

//--- logic/panel_scanner.sv
// CFT front-panel scanner
// Walks pc, dr, ac, sp one byte at a time, low half first, and
// latches each byte onto the panel lines with a one-cycle strobe

`include "cft_params.svh"

module panel_scanner
   import cft_pkg::*;
(
   input  logic  clk,
   input  logic  reset,
   // Byte returned by the arbiter for the current position
   input  half_t panel_byte,
   output src_t  panel_reg,
   output logic  panel_hi,
   output logic  panel_strobe,
   output half_t panel_data
);

   localparam int DWELL = `CFT_PANEL_DWELL;
   localparam int CNT_W = $clog2(DWELL);

   panel_state_t     state;
   logic [CNT_W-1:0] dwell_cnt;
   // Scan position, register index above, half select in bit 0
   logic [2:0]       pos;

   ////////////////////////////////////////////////////////////
   // Scanner FSM
   ////////////////////////////////////////////////////////////

   // DWELL-1 hold cycles plus one latch cycle per position
   always_ff @(posedge clk) begin
      if (reset) begin
         state        <= SCAN_IDLE;
         dwell_cnt    <= '0;
         pos          <= '0;
         panel_strobe <= 1'b0;
         panel_data   <= '0;
      end else begin
         case (state)
            SCAN_IDLE: begin
               state <= SCAN_HOLD;
            end
            SCAN_HOLD: begin
               if (dwell_cnt == CNT_W'(DWELL - 2)) begin
                  // Capture the byte as it stands on this edge
                  state        <= SCAN_LATCH;
                  panel_strobe <= 1'b1;
                  panel_data   <= panel_byte;
               end else begin
                  dwell_cnt <= dwell_cnt + 1'b1;
               end
            end
            SCAN_LATCH: begin
               // Next byte, wraps from sp high to pc low
               state        <= SCAN_HOLD;
               panel_strobe <= 1'b0;
               dwell_cnt    <= '0;
               pos          <= pos + 1'b1;
            end
            default: state <= SCAN_IDLE;
         endcase
      end
   end

   // Position to register code
   always_comb begin
      case (pos[2:1])
         2'd0:    panel_reg = `CFT_SRC_PC;
         2'd1:    panel_reg = `CFT_SRC_DR;
         2'd2:    panel_reg = `CFT_SRC_AC;
         default: panel_reg = `CFT_SRC_SP;
      endcase
   end
   assign panel_hi = pos[0];

   // Strobe is a single pulse, then quiet for the rest of the dwell
   a_strobe_spacing: assert property (
      @(posedge clk) disable iff (reset)
         panel_strobe |=> !panel_strobe [*(DWELL - 1)]
   ) else $error("panel_scanner: strobe spacing broken");

endmodule

//--- logic/cft_regs.sv
// CFT register section, top level
// Four major registers on one internal bus, the bus arbiter and the
// front-panel scanner

`include "cft_params.svh"

module cft_regs
   import cft_pkg::*;
(
   input  logic  clk,
   input  logic  reset,
   // Bus control codes
   input  src_t  read_sel,
   input  src_t  write_sel,
   input  word_t ext_data,
   // Count strobes
   input  logic  pc_inc,
   input  logic  dr_inc,
   input  logic  dr_dec,
   input  logic  ac_inc,
   input  logic  ac_dec,
   input  logic  sp_inc,
   input  logic  sp_dec,
   output word_t bus_out,
   output word_t pc_q,
   output word_t ac_q,
   // AC flags
   output logic  ac_z,
   output logic  ac_n,
   output logic  link,
   // Front panel
   output half_t panel_data,
   output logic  panel_strobe,
   output logic  panel_hi,
   output src_t  panel_reg
);

   word_t ibus;
   word_t dr_q;
   word_t sp_q;
   logic  pc_ld;
   logic  dr_ld;
   logic  ac_ld;
   logic  sp_ld;
   half_t panel_byte;

   // Bus leaves the chip on every cycle
   assign bus_out = ibus;

   ////////////////////////////////////////////////////////////
   // Major registers
   ////////////////////////////////////////////////////////////

   // PC counts up only
   reg_major #(.HAS_DEC(1'b0), .HAS_LINK(1'b0)) pc (
      .clk(clk), .reset(reset), .ld(pc_ld), .inc(pc_inc), .dec(1'b0),
      .d(ibus), .q(pc_q), .fz(), .fn(), .fl()
   );

   reg_major #(.HAS_DEC(1'b1), .HAS_LINK(1'b0)) dr (
      .clk(clk), .reset(reset), .ld(dr_ld), .inc(dr_inc), .dec(dr_dec),
      .d(ibus), .q(dr_q), .fz(), .fn(), .fl()
   );

   // AC carries the flags and the link
   reg_major #(.HAS_DEC(1'b1), .HAS_LINK(1'b1)) ac (
      .clk(clk), .reset(reset), .ld(ac_ld), .inc(ac_inc), .dec(ac_dec),
      .d(ibus), .q(ac_q), .fz(ac_z), .fn(ac_n), .fl(link)
   );

   reg_major #(.HAS_DEC(1'b1), .HAS_LINK(1'b0)) sp (
      .clk(clk), .reset(reset), .ld(sp_ld), .inc(sp_inc), .dec(sp_dec),
      .d(ibus), .q(sp_q), .fz(), .fn(), .fl()
   );

   // Bus and panel byte routing
   bus_arbiter arbiter (
      .read_sel(read_sel), .write_sel(write_sel), .panel_reg(panel_reg),
      .panel_hi(panel_hi), .pc_q(pc_q), .dr_q(dr_q), .ac_q(ac_q), .sp_q(sp_q),
      .ext_data(ext_data), .ibus(ibus), .pc_ld(pc_ld), .dr_ld(dr_ld),
      .ac_ld(ac_ld), .sp_ld(sp_ld), .panel_byte(panel_byte)
   );

   panel_scanner scanner (
      .clk(clk), .reset(reset), .panel_byte(panel_byte), .panel_reg(panel_reg),
      .panel_hi(panel_hi), .panel_strobe(panel_strobe), .panel_data(panel_data)
   );

endmodule

//--- verification/cft_regs_tb.sv
// CFT register section testbench
// Seeded random micro-operations on the four major registers, a
// directed down-count phase, and a model of registers, link and the
// front-panel scan order checked every cycle

`include "cft_params.svh"

module cft_regs_tb
   import cft_pkg::*;
();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int CLK_PERIOD   = 4;
   localparam int RESET_CYCLES = 5;
   localparam int N_RANDOM     = 2000;
   localparam int N_DIRECTED   = 20;
   localparam int MARGIN       = 50;
   localparam int DWELL        = `CFT_PANEL_DWELL;

   // DUT inputs
   logic  clk;
   logic  reset;
   src_t  read_sel;
   src_t  write_sel;
   word_t ext_data;
   logic  pc_inc;
   logic  dr_inc;
   logic  dr_dec;
   logic  ac_inc;
   logic  ac_dec;
   logic  sp_inc;
   logic  sp_dec;

   // DUT outputs
   word_t bus_out;
   word_t pc_q;
   word_t ac_q;
   logic  ac_z;
   logic  ac_n;
   logic  link;
   half_t panel_data;
   logic  panel_strobe;
   logic  panel_hi;
   src_t  panel_reg;

   // Model state
   word_t  m_pc;
   word_t  m_dr;
   word_t  m_ac;
   word_t  m_sp;
   logic   m_link;
   half_t  m_pdata;
   // Clock edges seen since reset release
   int     edge_cnt;
   integer seed;
   int     err_count;

   cft_regs cft_regs_i (
      .clk(clk), .reset(reset), .read_sel(read_sel), .write_sel(write_sel),
      .ext_data(ext_data), .pc_inc(pc_inc), .dr_inc(dr_inc), .dr_dec(dr_dec),
      .ac_inc(ac_inc), .ac_dec(ac_dec), .sp_inc(sp_inc), .sp_dec(sp_dec),
      .bus_out(bus_out), .pc_q(pc_q), .ac_q(ac_q), .ac_z(ac_z), .ac_n(ac_n),
      .link(link), .panel_data(panel_data), .panel_strobe(panel_strobe),
      .panel_hi(panel_hi), .panel_reg(panel_reg)
   );

   // 4 ns clock
   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   ////////////////////////////////////////////////////////////
   // Model helpers
   ////////////////////////////////////////////////////////////

   // Word on the bus for a source code, unused codes read zero
   function automatic word_t bus_value(input src_t sel);
      case (sel)
         `CFT_SRC_PC:  return m_pc;
         `CFT_SRC_DR:  return m_dr;
         `CFT_SRC_AC:  return m_ac;
         `CFT_SRC_SP:  return m_sp;
         `CFT_SRC_EXT: return ext_data;
         default:      return '0;
      endcase
   endfunction

   // Load beats increment, increment beats decrement
   function automatic word_t next_value(input word_t v, input logic ld, input logic inc,
                                        input logic dec, input word_t bus);
      if (ld)
         return bus;
      else if (inc)
         return v + 16'd1;
      else if (dec)
         return v - 16'd1;
      return v;
   endfunction

   // Scan position 0..7, pc low first, sp high last
   function automatic src_t pos_reg(input int p);
      case (p / 2)
         0:       return `CFT_SRC_PC;
         1:       return `CFT_SRC_DR;
         2:       return `CFT_SRC_AC;
         default: return `CFT_SRC_SP;
      endcase
   endfunction

   function automatic half_t reg_half(input int p);
      word_t w;
      w = bus_value(pos_reg(p));
      if (p % 2 != 0)
         return w[`CFT_WORD_W-1:`CFT_WORD_W/2];
      return w[`CFT_WORD_W/2-1:0];
   endfunction

   // Advance the model by one edge, using the inputs the DUT sees
   task automatic update_model();
      word_t bus;
      int    k;
      k   = edge_cnt;
      bus = bus_value(read_sel);
      // Panel byte taken from the registers as they stand before the edge
      if (k % DWELL == DWELL - 1)
         m_pdata = reg_half((k / DWELL) % 8);
      // Link flips on carry or borrow, a load masks both
      if (write_sel != `CFT_SRC_AC) begin
         if (ac_inc && m_ac == 16'hFFFF)
            m_link = ~m_link;
         else if (!ac_inc && ac_dec && m_ac == 16'h0000)
            m_link = ~m_link;
      end
      // PC has no down count
      m_pc = next_value(m_pc, write_sel == `CFT_SRC_PC, pc_inc, 1'b0, bus);
      m_dr = next_value(m_dr, write_sel == `CFT_SRC_DR, dr_inc, dr_dec, bus);
      m_ac = next_value(m_ac, write_sel == `CFT_SRC_AC, ac_inc, ac_dec, bus);
      m_sp = next_value(m_sp, write_sel == `CFT_SRC_SP, sp_inc, sp_dec, bus);
      edge_cnt = edge_cnt + 1;
   endtask

   ////////////////////////////////////////////////////////////
   // Checks
   ////////////////////////////////////////////////////////////

   task automatic check_value(input string name, input logic [15:0] got,
                              input logic [15:0] exp);
      if (got !== exp) begin
         err_count = err_count + 1;
         $display("MISMATCH %s: got %h, expected %h", name, got, exp);
         $display("Test failed");
         $fatal(1, "stopping at first error");
      end
   endtask

   // Outputs half a cycle after the edge
   task automatic check_outputs();
      int k;
      int p;
      k = edge_cnt - 1;
      p = (k / DWELL) % 8;
      check_value("bus_out", bus_out, bus_value(read_sel));
      check_value("pc_q", pc_q, m_pc);
      check_value("ac_q", ac_q, m_ac);
      check_value("ac_z", 16'(ac_z), 16'(m_ac == 16'h0000));
      check_value("ac_n", 16'(ac_n), 16'(m_ac[`CFT_WORD_W-1]));
      check_value("link", 16'(link), 16'(m_link));
      // Strobe after the last edge of each dwell window
      check_value("panel_strobe", 16'(panel_strobe), 16'(k % DWELL == DWELL - 1));
      check_value("panel_reg", 16'(panel_reg), 16'(pos_reg(p)));
      check_value("panel_hi", 16'(panel_hi), 16'(p % 2 != 0));
      check_value("panel_data", 16'(panel_data), 16'(m_pdata));
   endtask

   // One bus cycle
   // cnt order is pc_inc, dr_inc, dr_dec, ac_inc, ac_dec, sp_inc, sp_dec
   task automatic run_cycle(input src_t rs, input src_t ws, input word_t ext,
                            input logic [6:0] cnt);
      @(posedge clk);
      update_model();
      read_sel  <= rs;
      write_sel <= ws;
      ext_data  <= ext;
      {pc_inc, dr_inc, dr_dec, ac_inc, ac_dec, sp_inc, sp_dec} <= cnt;
      @(negedge clk);
      check_outputs();
   endtask

   // Count strobes from random bits, never up and down together
   function automatic logic [6:0] draw_counts(input logic [31:0] r);
      logic [6:0] c;
      c[6] = (r[7:6] == 2'd1);
      c[5] = (r[9:8] == 2'd1);
      c[4] = (r[9:8] == 2'd2);
      c[3] = (r[11:10] == 2'd1);
      c[2] = (r[11:10] == 2'd2);
      c[1] = (r[13:12] == 2'd1);
      c[0] = (r[13:12] == 2'd2);
      return c;
   endfunction

   // External word, biased toward the wrap corners
   function automatic word_t draw_ext(input logic [31:0] r);
      if (r[17:16] != 2'd0)
         return r[15:0];
      case (r[1:0])
         2'd0:    return 16'hFFFF;
         2'd1:    return 16'h0000;
         2'd2:    return 16'h7FFF;
         default: return 16'h8000;
      endcase
   endfunction

   ////////////////////////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////////////////////////

   initial begin
      logic [31:0] rnd;
      logic [31:0] rnd_ext;
      seed      = 67616;
      err_count = 0;
      edge_cnt  = 0;
      m_pc      = '0;
      m_dr      = '0;
      m_ac      = '0;
      m_sp      = '0;
      m_link    = 1'b0;
      m_pdata   = '0;
      reset     = 1'b1;
      read_sel  = `CFT_SRC_NONE;
      write_sel = `CFT_SRC_NONE;
      ext_data  = '0;
      {pc_inc, dr_inc, dr_dec, ac_inc, ac_dec, sp_inc, sp_dec} = '0;
      repeat (RESET_CYCLES) @(posedge clk);
      reset <= 1'b0;

      // Random micro-operations, every code 0..7 on both selects
      for (int i = 0; i < N_RANDOM; i++) begin
         rnd     = $random(seed);
         rnd_ext = $random(seed);
         run_cycle(rnd[2:0], rnd[5:3], draw_ext(rnd_ext), draw_counts(rnd));
      end

      // DR and SP count down through zero
      run_cycle(`CFT_SRC_EXT, `CFT_SRC_DR, 16'h0002, 7'b0000000);
      run_cycle(`CFT_SRC_EXT, `CFT_SRC_SP, 16'h0001, 7'b0000000);
      repeat (4) run_cycle(`CFT_SRC_DR, `CFT_SRC_NONE, 16'h0000, 7'b0010001);
      run_cycle(`CFT_SRC_SP, `CFT_SRC_NONE, 16'h0000, 7'b0000000);
      // AC borrow, then carry, then a load that hides a carry
      run_cycle(`CFT_SRC_EXT, `CFT_SRC_AC, 16'h0000, 7'b0000000);
      run_cycle(`CFT_SRC_AC, `CFT_SRC_NONE, 16'h0000, 7'b0000100);
      run_cycle(`CFT_SRC_AC, `CFT_SRC_NONE, 16'h0000, 7'b0001000);
      run_cycle(`CFT_SRC_EXT, `CFT_SRC_AC, 16'hFFFF, 7'b0000000);
      // AC holds FFFF here, the load wins over the increment
      run_cycle(`CFT_SRC_EXT, `CFT_SRC_AC, 16'h0005, 7'b0001000);
      run_cycle(`CFT_SRC_AC, `CFT_SRC_NONE, 16'h0000, 7'b0000000);
      // PC rolls over, ext code on write_sel loads nothing
      run_cycle(`CFT_SRC_EXT, `CFT_SRC_PC, 16'hFFFF, 7'b1000000);
      run_cycle(`CFT_SRC_EXT, `CFT_SRC_EXT, 16'h1234, 7'b1000000);
      run_cycle(`CFT_SRC_NONE, `CFT_SRC_NONE, 16'h0000, 7'b0000000);
      run_cycle(`CFT_SRC_NONE, `CFT_SRC_NONE, 16'h0000, 7'b0000000);

      if (err_count == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

   // Watchdog sized from reset, random and directed phases
   initial begin
      #((RESET_CYCLES + N_RANDOM + N_DIRECTED + MARGIN) * CLK_PERIOD);
      $display("Timeout: the stimulus did not finish in the expected time");
      $display("Test failed");
      $fatal(1, "watchdog expired");
   end

endmodule

//--- tb.f
+incdir+logic
logic/cft_pkg.sv
logic/reg_major.sv
logic/bus_arbiter.sv
logic/panel_scanner.sv
logic/cft_regs.sv
verification/cft_regs_tb.sv

//--- Makefile
TOP = cft_regs_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f tb.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^Test passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
